// ==== Makefile ====
# Verilator build and run for the 8x8 IDCT block engine

VERILATOR ?= verilator
TOP       ?= tb_idct_block
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := hdl/idct_defs.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '^ALL CHECKS PASSED$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/coeff_buffer.sv ====
// Coefficient input buffer
// Stores one 8x8 block of strobed coefficients in row-major order
// and holds the loaded level until the engine has read the block
`timescale 1ns/10ps
`default_nettype none

`include "idct_defs.svh"

module coeff_buffer (
	input  logic                Clock,
	input  logic                resetn,
	input  logic                coeff_valid,
	input  idct_pkg::coeff_t    coeff,
	input  logic                consumed,
	input  idct_pkg::blk_addr_t rd_addr,
	output idct_pkg::coeff_t    rd_data,
	output logic                loaded
);

	idct_pkg::coeff_t mem [`IDCT_SIZE];
	idct_pkg::blk_addr_t wr_idx;

	always_ff @(posedge Clock or negedge resetn) begin
		if (resetn == 1'b0) begin
			wr_idx <= '0;
			loaded <= 1'b0;
		end else begin
			if (coeff_valid) begin
				wr_idx <= wr_idx + 1'b1; // Wraps after 64
			end
			if (consumed) begin
				loaded <= 1'b0;
			end else if (coeff_valid && wr_idx == idct_pkg::blk_addr_t'(`IDCT_SIZE - 1)) begin
				loaded <= 1'b1;
			end
		end
	end

	// Storage and registered read port
	always_ff @(posedge Clock) begin
		if (coeff_valid) begin
			mem[wr_idx] <= coeff;
		end
		rd_data <= mem[rd_addr];
	end

	// Sender must hold off while a full block waits for the engine
	a_no_strobe_when_busy: assert property (
		@(posedge Clock) disable iff (resetn == 1'b0)
		loaded |-> !coeff_valid
	) else $error("coefficient strobed while busy");

endmodule

`default_nettype wire

// ==== hdl/idct_block.sv ====
// 8x8 inverse DCT block engine, top level
// Coefficient buffer, two-pass transform engine and pixel packer
`timescale 1ns/10ps
`default_nettype none

module idct_block (
	input  logic             Clock,
	input  logic             resetn,
	input  logic             coeff_valid,
	input  idct_pkg::coeff_t coeff,
	output logic             busy,
	output idct_pkg::word_t  pix_word,
	output logic             pix_word_valid,
	output logic             block_done
);

	idct_pkg::blk_addr_t rd_addr;
	idct_pkg::coeff_t rd_data;
	logic consumed;
	idct_pkg::pix_beat_t beat;

	coeff_buffer coeff_buffer_inst (
		.Clock       (Clock),
		.resetn      (resetn),
		.coeff_valid (coeff_valid),
		.coeff       (coeff),
		.consumed    (consumed),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.loaded      (busy)      // Full block waiting
	);

	idct_engine idct_engine_inst (
		.Clock    (Clock),
		.resetn   (resetn),
		.loaded   (busy),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.consumed (consumed),
		.beat     (beat)
	);

	pixel_packer pixel_packer_inst (
		.Clock          (Clock),
		.resetn         (resetn),
		.beat           (beat),
		.pix_word       (pix_word),
		.pix_word_valid (pix_word_valid),
		.block_done     (block_done)
	);

endmodule

`default_nettype wire

// ==== hdl/idct_defs.svh ====
// IDCT block engine constants
// Block geometry, datapath widths and fixed point shift amounts
`ifndef IDCT_DEFS_SVH
`define IDCT_DEFS_SVH

// Block geometry
`define IDCT_N      8
`define IDCT_SIZE   64

// Datapath widths
`define COEFF_W     16  // Input coefficient
`define PIXEL_W     8
`define WORD_W      16  // Two pixels per output word
`define ACC_W       32  // Accumulator and stored T value
`define CTAB_W      12  // Basis table entry, signed

// Fixed point scaling
`define PASS1_SHIFT 8
`define CLIP_LSB    16  // Pixel taken from bits 23:16 in pass 2

`endif

// ==== hdl/idct_engine.sv ====
// IDCT processing engine
// Pass 1 computes T = S'*C from the coefficient buffer, pass 2 computes
// S = Ct*T from the internal T memory and clips to 8-bit pixels.
// Two multipliers, four accumulate cycles per output value
`timescale 1ns/10ps
`default_nettype none

`include "idct_defs.svh"

module idct_engine (
	input  logic                 Clock,
	input  logic                 resetn,
	input  logic                 loaded,
	output idct_pkg::blk_addr_t  rd_addr,
	input  idct_pkg::coeff_t     rd_data,
	output logic                 consumed,
	output idct_pkg::pix_beat_t  beat
);

	idct_pkg::engine_state_t state;
	logic prime;          // Row 0 prefetch before pass 1 starts
	logic [2:0] row, col;
	logic [1:0] step;     // Coefficient pair k = 2*step, 2*step+1
	logic [2:0] frow;
	logic a_act, fetch_en, fetch_d;
	idct_pkg::blk_addr_t fetch_addr_d;

	idct_pkg::coeff_t row_buf [2][`IDCT_N]; // Ping-pong S' rows
	idct_pkg::acc_t tmem [`IDCT_SIZE];

	idct_pkg::acc_t op0, op1, acc, prod0, prod1, sum;
	idct_pkg::blk_addr_t idx0, idx1, b_pos;
	idct_pkg::ctab_t c0, c1;
	logic b_vld, b_first, b_last, b_pass2;
	idct_pkg::pixel_t pix_clip, beat_pix;
	logic beat_vld, beat_last;

	assign a_act = (state == idct_pkg::PASS1 && !prime) || state == idct_pkg::PASS2;

	// One S' read per output of the current row fetches the next row
	assign frow = prime ? row : row + 3'd1;
	assign fetch_en = state == idct_pkg::PASS1 && (prime || (step == 2'd0 && row != 3'd7));
	assign rd_addr = {frow, col};

	assign consumed = (state == idct_pkg::DRAIN1);

	always_ff @(posedge Clock or negedge resetn) begin
		if (resetn == 1'b0) begin
			state <= idct_pkg::IDLE;
			prime <= 1'b0;
			row <= '0;
			col <= '0;
			step <= '0;
			fetch_d <= 1'b0;
			b_vld <= 1'b0;
			b_first <= 1'b0;
			b_last <= 1'b0;
			b_pass2 <= 1'b0;
			beat_vld <= 1'b0;
			beat_last <= 1'b0;
		end else begin
			fetch_d <= fetch_en;
			b_vld <= a_act;
			b_first <= (step == 2'd0);
			b_last <= (step == 2'd3);
			b_pass2 <= (state == idct_pkg::PASS2);
			beat_vld <= b_vld && b_last && b_pass2;
			beat_last <= b_vld && b_last && b_pass2 && b_pos == idct_pkg::blk_addr_t'(`IDCT_SIZE - 1);
			case (state)
				idct_pkg::IDLE: begin
					if (loaded) begin
						state <= idct_pkg::PASS1;
						prime <= 1'b1;
					end
				end
				idct_pkg::PASS1, idct_pkg::PASS2: begin
					if (prime) begin
						col <= col + 3'd1;
						if (col == 3'd7) prime <= 1'b0;
					end else begin
						step <= step + 2'd1;
						if (step == 2'd3) begin
							col <= col + 3'd1;
							if (col == 3'd7) begin
								row <= row + 3'd1;
								if (row == 3'd7) begin // Counters wrap to zero
									state <= (state == idct_pkg::PASS1) ? idct_pkg::DRAIN1
										: idct_pkg::DRAIN2;
								end
							end
						end
					end
				end
				idct_pkg::DRAIN1: state <= idct_pkg::PASS2;
				default: state <= idct_pkg::IDLE;
			endcase
		end
	end

	assign c0 = idct_pkg::basis_coeff(idx0);
	assign c1 = idct_pkg::basis_coeff(idx1);
	assign prod0 = op0 * idct_pkg::acc_t'(c0);
	assign prod1 = op1 * idct_pkg::acc_t'(c1);
	assign sum = (b_first ? idct_pkg::acc_t'(0) : acc) + prod0 + prod1;

	// Negative gives 0, overflow above bit 23 gives 255
	assign pix_clip = sum[`ACC_W-1] ? '0
		: (|sum[`ACC_W-2:`CLIP_LSB+`PIXEL_W]) ? '1
		: sum[`CLIP_LSB+`PIXEL_W-1:`CLIP_LSB];

	always_ff @(posedge Clock) begin
		if (fetch_d) begin
			row_buf[fetch_addr_d[3]][fetch_addr_d[2:0]] <= rd_data;
		end
		fetch_addr_d <= rd_addr;
		if (a_act) begin
			if (state == idct_pkg::PASS1) begin
				op0 <= idct_pkg::acc_t'(row_buf[row[0]][{step, 1'b0}]);
				op1 <= idct_pkg::acc_t'(row_buf[row[0]][{step, 1'b1}]);
				idx0 <= {step, 1'b0, col};
				idx1 <= {step, 1'b1, col};
			end else begin
				op0 <= tmem[{step, 1'b0, col}]; // T(k,c)
				op1 <= tmem[{step, 1'b1, col}];
				idx0 <= {step, 1'b0, row};       // Transposed table
				idx1 <= {step, 1'b1, row};
			end
			b_pos <= {row, col};
		end
		if (b_vld) begin
			acc <= sum;
		end
		if (b_vld && b_last && !b_pass2) begin
			tmem[b_pos] <= sum >>> `PASS1_SHIFT;
		end
		if (b_vld && b_last && b_pass2) begin
			beat_pix <= pix_clip;
		end
	end

	assign beat = '{valid: beat_vld, last: beat_last, pixel: beat_pix};

	// Release only a block that the buffer still holds
	a_consumed_while_loaded: assert property (
		@(posedge Clock) disable iff (resetn == 1'b0)
		consumed |-> loaded
	) else $error("consumed with no block loaded");

	a_beat_from_pass2: assert property (
		@(posedge Clock) disable iff (resetn == 1'b0)
		beat.valid |-> $past(state) inside {idct_pkg::PASS2, idct_pkg::DRAIN2}
	) else $error("pixel beat outside pass 2");

endmodule

`default_nettype wire

// ==== hdl/idct_pkg.sv ====
// IDCT shared types
// Vector types, the pixel beat passed from engine to packer,
// engine FSM states and the cosine basis table
`default_nettype none

`include "idct_defs.svh"

package idct_pkg;

	typedef logic signed [`COEFF_W-1:0] coeff_t;
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic signed [`CTAB_W-1:0] ctab_t;
	typedef logic [$clog2(`IDCT_SIZE)-1:0] blk_addr_t; // row*8 + col
	typedef logic [`PIXEL_W-1:0] pixel_t;
	typedef logic [`WORD_W-1:0] word_t;

	typedef struct packed {
		logic valid;
		logic last;   // Pixel (7,7)
		pixel_t pixel;
	} pix_beat_t;

	typedef enum logic [2:0] {
		IDLE,
		PASS1,
		DRAIN1,
		PASS2,
		DRAIN2
	} engine_state_t;

	// Entry C[k][c] for idx = k*8 + c
	// Scaled by 2048, row 0 carries the 1/sqrt(2) factor
	function automatic ctab_t basis_coeff(input blk_addr_t idx);
		int k;
		int m;
		int mag;
		logic neg;
		k = int'(idx[5:3]);
		m = ((2 * int'(idx[2:0]) + 1) * k) % 32; // Angle in units of pi/16
		if (m > 16) begin
			m = 32 - m; // cos is even around pi
		end
		neg = (m > 8);
		if (neg) begin
			m = 16 - m;
		end
		case (m)
			0, 4: mag = 1448; // DC row shares the pi/4 value
			1: mag = 2008;
			2: mag = 1892;
			3: mag = 1702;
			5: mag = 1137;
			6: mag = 783;
			7: mag = 399;
			default: mag = 0;
		endcase
		return ctab_t'(neg ? -mag : mag);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/pixel_packer.sv ====
// Pixel packer
// Pairs horizontally adjacent pixels into 16-bit words, even pixel in
// the high byte, and flags the last word of each block
`timescale 1ns/10ps
`default_nettype none

module pixel_packer (
	input  logic                Clock,
	input  logic                resetn,
	input  idct_pkg::pix_beat_t beat,
	output idct_pkg::word_t     pix_word,
	output logic                pix_word_valid,
	output logic                block_done
);

	logic phase;               // High after an even column pixel
	idct_pkg::pixel_t held;

	always_ff @(posedge Clock or negedge resetn) begin
		if (resetn == 1'b0) begin
			phase <= 1'b0;
			pix_word_valid <= 1'b0;
			block_done <= 1'b0;
		end else begin
			pix_word_valid <= beat.valid && phase;
			block_done <= beat.valid && phase && beat.last;
			if (beat.valid) begin
				phase <= ~phase;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (beat.valid && !phase) begin
			held <= beat.pixel;
		end
		if (beat.valid && phase) begin
			pix_word <= {held, beat.pixel};
		end
	end

	// Engine spaces beats by at least 4 cycles
	a_no_adjacent_beats: assert property (
		@(posedge Clock) disable iff (resetn == 1'b0)
		beat.valid |=> !beat.valid
	) else $error("pixel beats on adjacent cycles");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/idct_pkg.sv
hdl/coeff_buffer.sv
hdl/idct_engine.sv
hdl/pixel_packer.sv
hdl/idct_block.sv
tb/clock_gen.sv
tb/tb_idct_block.sv

// ==== tb/clock_gen.sv ====
// Testbench clock source
// Free running clock, low at time zero
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS = 8
) (
	output logic Clock
);

	initial begin
		Clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2) Clock = ~Clock;
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_idct_block.sv ====
// Testbench for the 8x8 IDCT block engine
// Sends coefficient blocks, models both passes and the clipping,
// and checks every packed pixel word and block_done pulse
`timescale 1ns/10ps
`default_nettype none

`include "idct_defs.svh"

module tb_idct_block;

	localparam int NUM_BLOCKS = 14;
	localparam int CYCLES_PER_BLOCK = 700;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * CYCLES_PER_BLOCK;
	localparam int WORDS_PER_BLOCK = `IDCT_SIZE / 2;

	typedef idct_pkg::coeff_t block_t [`IDCT_SIZE];
	typedef idct_pkg::word_t words_t [WORDS_PER_BLOCK];

	logic Clock;
	logic resetn;
	logic coeff_valid;
	idct_pkg::coeff_t coeff;
	logic busy;
	idct_pkg::word_t pix_word;
	logic pix_word_valid;
	logic block_done;

	idct_pkg::word_t exp_q [$];   // Expected words of all blocks in flight
	string test_name = "none";
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int blocks_sent = 0;
	int blocks_done = 0;
	int words_in_block = 0;
	int cycle_count = 0;

	clock_gen #(.PERIOD_NS(8)) clock_gen_inst (.Clock(Clock));

	idct_block idct_block_inst (
		.Clock          (Clock),
		.resetn         (resetn),
		.coeff_valid    (coeff_valid),
		.coeff          (coeff),
		.busy           (busy),
		.pix_word       (pix_word),
		.pix_word_valid (pix_word_valid),
		.block_done     (block_done)
	);

	// Negative to 0, anything at or above bit 24 to 255
	function automatic idct_pkg::pixel_t clip_pixel(input int sum);
		if (sum < 0) begin
			return '0;
		end
		if (sum >= (1 << (`CLIP_LSB + `PIXEL_W))) begin
			return '1;
		end
		return idct_pkg::pixel_t'(sum >> `CLIP_LSB);
	endfunction

	// Reference model, T = S'*C then S = Ct*T
	function automatic void ref_words(input block_t blk, output words_t words);
		int t [`IDCT_SIZE];
		idct_pkg::pixel_t pix [`IDCT_SIZE];
		int acc;
		for (int r = 0; r < `IDCT_N; r++) begin
			for (int c = 0; c < `IDCT_N; c++) begin
				acc = 0;
				for (int k = 0; k < `IDCT_N; k++) begin
					acc += int'(blk[r * `IDCT_N + k])
						* int'(idct_pkg::basis_coeff(idct_pkg::blk_addr_t'(k * `IDCT_N + c)));
				end
				t[r * `IDCT_N + c] = acc >>> `PASS1_SHIFT;
			end
		end
		for (int r = 0; r < `IDCT_N; r++) begin
			for (int c = 0; c < `IDCT_N; c++) begin
				acc = 0;
				for (int k = 0; k < `IDCT_N; k++) begin
					acc += int'(idct_pkg::basis_coeff(idct_pkg::blk_addr_t'(k * `IDCT_N + r)))
						* t[k * `IDCT_N + c];
				end
				pix[r * `IDCT_N + c] = clip_pixel(acc);
			end
		end
		for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
			words[i] = {pix[2 * i], pix[2 * i + 1]}; // Even column in high byte
		end
	endfunction

	task automatic send_block(input block_t blk);
		words_t words;
		ref_words(blk, words);
		foreach (words[i]) begin
			exp_q.push_back(words[i]);
		end
		blocks_sent++;
		for (int i = 0; i < `IDCT_SIZE; i++) begin
			@(negedge Clock);
			while (busy) begin
				coeff_valid = 1'b0; // Previous block still waiting for the engine
				@(negedge Clock);
			end
			coeff_valid = 1'b1;
			coeff = blk[i];
		end
		@(negedge Clock);
		coeff_valid = 1'b0;
	endtask

	task automatic fill_random(output block_t blk);
		foreach (blk[i]) begin
			blk[i] = idct_pkg::coeff_t'(int'($urandom % 1024) - 512);
		end
	endtask

	task automatic send_dc_block(input idct_pkg::coeff_t dc);
		block_t blk;
		foreach (blk[i]) begin
			blk[i] = '0;
		end
		blk[0] = dc;
		send_block(blk);
	endtask

	task automatic wait_all_done();
		while (blocks_done < blocks_sent) begin
			@(negedge Clock);
		end
	endtask

	task automatic start_test(input string name, output int start_errors);
		test_name = name;
		start_errors = error_count;
		tests_run++;
	endtask

	task automatic close_test(input int start_errors);
		if (exp_q.size() != 0) begin
			$display("%s: %0d expected words never arrived", test_name, exp_q.size());
			error_count++;
		end
		if (blocks_done != blocks_sent) begin
			$display("%s: block_done count %0d does not match %0d blocks sent", test_name,
				blocks_done, blocks_sent);
			error_count++;
		end
		if (words_in_block != 0) begin
			$display("%s: %0d words of an unfinished block arrived", test_name,
				words_in_block);
			error_count++;
		end
		if (error_count == start_errors) begin
			$display("test %s passed", test_name);
		end else begin
			$display("test %s failed with %0d errors", test_name, error_count - start_errors);
			tests_failed++;
		end
	endtask

	// Compare each word as it leaves the DUT
	always @(negedge Clock) begin : compare_words
		idct_pkg::word_t exp_word;
		if (resetn) begin
			if (pix_word_valid) begin
				if (exp_q.size() == 0) begin
					$display("%s: pixel word 0x%04h arrived with no block outstanding",
						test_name, pix_word);
					error_count++;
				end else begin
					exp_word = exp_q.pop_front();
					if (pix_word !== exp_word) begin
						$display("ERROR %s: word %0d expected 0x%04h actual 0x%04h", test_name,
							words_in_block, exp_word, pix_word);
						error_count++;
					end
				end
				words_in_block++;
			end
			if (block_done) begin
				if (words_in_block != WORDS_PER_BLOCK) begin
					$display("ERROR %s: words per block expected %0d actual %0d", test_name,
						WORDS_PER_BLOCK, words_in_block);
					error_count++;
				end
				words_in_block = 0;
				blocks_done++;
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge Clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles, %0d of %0d blocks finished", cycle_count,
			blocks_done, blocks_sent);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : stimulus
		block_t blk;
		int start_errors;
		int done_before;
		resetn = 1'b0;
		coeff_valid = 1'b0;
		coeff = '0;
		void'($urandom(32'h0a350a36));
		repeat (10) @(negedge Clock);
		resetn = 1'b1;

		start_test("reset_idle", start_errors);
		repeat (20) begin
			@(negedge Clock);
			if (busy || pix_word_valid || block_done) begin
				$display("ERROR %s: busy/pix_word_valid/block_done expected 000 actual %b%b%b",
					test_name, busy, pix_word_valid, block_done);
				error_count++;
			end
		end
		close_test(start_errors);

		start_test("zero_block", start_errors);
		send_dc_block('0);
		wait_all_done();
		close_test(start_errors);

		start_test("dc_only", start_errors);
		send_dc_block(16'sd1000);   // Mid gray
		wait_all_done();
		send_dc_block(16'sd32767);  // Saturates at 255
		wait_all_done();
		send_dc_block(-16'sd32768); // Clips to 0
		wait_all_done();
		close_test(start_errors);

		start_test("random_blocks", start_errors);
		repeat (8) begin
			fill_random(blk);
			send_block(blk);
			wait_all_done();
		end
		close_test(start_errors);

		// Second block loads while the first is in pass 2
		start_test("overlap", start_errors);
		done_before = blocks_done;
		fill_random(blk);
		send_block(blk);
		fill_random(blk);
		send_block(blk);
		if (blocks_done != done_before) begin
			$display("%s: first block finished before the second block was loaded", test_name);
			error_count++;
		end
		wait_all_done();
		close_test(start_errors);

		$display("tests %0d, failed %0d, blocks %0d, errors %0d", tests_run, tests_failed,
			blocks_done, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
